/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen       = 32;  // Data word width
    localparam int reg_addr_w = 5;   // 32 architectural registers
    localparam int byte_w     = 8;
    localparam int half_w     = 16;

    localparam int bytes_per_word = xlen / byte_w;
    localparam int halves_per_word = xlen / half_w;

    // Load op encoding taken straight from funct3
    typedef enum logic [2:0] {
        lb  = 3'b000,  // Signed byte
        lh  = 3'b001,  // Signed halfword
        lw  = 3'b010,  // Full word
        lbu = 3'b100,  // Unsigned byte
        lhu = 3'b101   // Unsigned halfword
    } load_op_t;

endpackage

/* design/core_pkg.sv */
package core_pkg;

    import rv_isa_pkg::*;

    localparam int load_queue_depth = 4;  // Outstanding load commands

    // One register writeback, as produced by any source
    typedef struct packed {
        logic [reg_addr_w-1:0] addr;         // Destination register
        logic [xlen-1:0]       value;
        logic                  speculative;
    } core_result_t;

    // Load command issued at the memory stage
    typedef struct packed {
        logic [reg_addr_w-1:0] addr;    // Destination register
        logic [1:0]            offset;  // Byte offset inside the word
        load_op_t              op;
    } load_cmd_t;

    // Memory data word, split for sub-word loads
    typedef union packed {
        logic [bytes_per_word-1:0][byte_w-1:0]  bytes;
        logic [halves_per_word-1:0][half_w-1:0] halves;
    } mem_word_u;

endpackage

/* design/load_align.sv */
module load_align (
    input  core_pkg::load_cmd_t    cmd,
    input  core_pkg::mem_word_u    data,
    output core_pkg::core_result_t result
);

    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [byte_w-1:0] byte_sel;  // Addressed byte
    logic [half_w-1:0] half_sel;  // Addressed halfword
    logic [xlen-1:0]   value;

    always_comb begin
        byte_sel = data.bytes[cmd.offset];
        half_sel = data.halves[cmd.offset[1]];  // Bit 0 ignored for halfwords
    end

    always_comb begin
        case (cmd.op)
            lb: begin
                value = {{(xlen - byte_w){byte_sel[byte_w-1]}}, byte_sel};
            end
            lbu: begin
                value = {{(xlen - byte_w){1'b0}}, byte_sel};
            end
            lh: begin
                value = {{(xlen - half_w){half_sel[half_w-1]}}, half_sel};
            end
            lhu: begin
                value = {{(xlen - half_w){1'b0}}, half_sel};
            end
            default: begin
                value = data.bytes;  // lw, whole word
            end
        endcase
    end

    always_comb begin
        result.addr        = cmd.addr;
        result.value       = value;
        result.speculative = 1'b0;  // Loads are never speculative here
    end

endmodule

/* design/load_cmd_queue.sv */
module load_cmd_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                push_valid,
    output logic                push_ready,
    input  core_pkg::load_cmd_t push_cmd,
    output logic                head_valid,
    output core_pkg::load_cmd_t head,
    input  logic                pop
);

    import core_pkg::*;

    localparam int ptr_w = $clog2(load_queue_depth);

    load_cmd_t entries [load_queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;     // One extra bit to tell full from empty
    logic             full;
    logic             push_fire;
    logic             pop_fire;

    always_comb begin
        full       = (count == (ptr_w + 1)'(load_queue_depth));
        head_valid = (count != '0);
        head       = entries[rd_ptr];
        push_ready = !full || pop;  // A pop frees the slot in the same cycle
        push_fire  = push_valid && push_ready;
        pop_fire   = pop && head_valid;
    end

    // Storage, no reset needed on entries
    always_ff @(posedge clk) begin
        if (push_fire) begin
            entries[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth, power of two
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

/* design/writeback_arbiter.sv */
module writeback_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   exec_valid,
    output logic                   exec_ready,
    input  core_pkg::core_result_t exec_result,
    input  logic                   sys_valid,
    output logic                   sys_ready,
    input  core_pkg::core_result_t sys_result,
    input  logic                   load_valid,
    input  core_pkg::core_result_t load_result,
    output logic                   load_take,
    output logic                   wb_valid,
    input  logic                   wb_ready,
    output core_pkg::core_result_t wb_result
);

    import core_pkg::*;

    // Priority states double as candidate bit positions
    typedef enum logic [1:0] {
        prio_exec = 2'd0,
        prio_load = 2'd1,
        prio_sys  = 2'd2
    } prio_t;

    prio_t        prio_q;
    prio_t        prio_next;
    logic         accept;   // Output register can take a result
    logic [2:0]   cand;     // Candidate valids by source
    logic [2:0]   grant;    // One-hot winner
    logic         fire;     // Transfer into the output register
    core_result_t winner;

    // First requester in cyclic order from the priority holder
    function automatic logic [2:0] pick(input logic [2:0] req, input prio_t start);
        logic [2:0]  gnt;
        logic        found;
        int unsigned idx;
        gnt   = '0;
        found = 1'b0;
        for (int i = 0; i < 3; i++) begin
            idx = (int'(start) + i) % 3;
            if (!found && req[idx]) begin
                gnt[idx] = 1'b1;
                found    = 1'b1;
            end
        end
        return gnt;
    endfunction

    always_comb begin
        case (prio_q)
            prio_exec: prio_next = prio_load;
            prio_load: prio_next = prio_sys;
            default:   prio_next = prio_exec;
        endcase
    end

    always_comb begin
        accept = !wb_valid || wb_ready;

        cand            = '0;
        cand[prio_exec] = exec_valid;
        cand[prio_load] = load_valid;
        cand[prio_sys]  = sys_valid;

        grant = accept ? pick(cand, prio_q) : 3'b000;
        fire  = |grant;

        exec_ready = grant[prio_exec];
        load_take  = grant[prio_load];  // Pops queue and memory together
        sys_ready  = grant[prio_sys];
    end

    always_comb begin
        if (grant[prio_load]) begin
            winner             = load_result;
            winner.speculative = 1'b0;
        end else if (grant[prio_sys]) begin
            winner = sys_result;
        end else begin
            winner = exec_result;  // Also the idle default
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_q   <= prio_exec;
            wb_valid <= 1'b0;
        end else begin
            if (fire) begin
                prio_q <= prio_next;  // Advance on every accepted input
            end
            if (fire) begin
                wb_valid <= 1'b1;
            end else if (wb_ready) begin
                wb_valid <= 1'b0;  // Drained with nothing new
            end
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (fire) begin
            wb_result <= winner;
        end
    end

endmodule

/* design/reg_file.sv */
module reg_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wr_valid,
    input  core_pkg::core_result_t             wr,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs1_addr,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs2_addr,
    output logic [rv_isa_pkg::xlen-1:0]        rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]        rs2_data
);

    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [1:num_regs-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.value;  // Writes to x0 dropped
        end
    end

    // Combinational read ports for decode
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end

        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

/* design/writeback_top.sv */
module writeback_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              exec_valid,
    output logic                              exec_ready,
    input  core_pkg::core_result_t            exec_result,
    input  logic                              sys_valid,
    output logic                              sys_ready,
    input  core_pkg::core_result_t            sys_result,
    input  logic                              load_cmd_valid,
    output logic                              load_cmd_ready,
    input  core_pkg::load_cmd_t               load_cmd,
    input  logic                              mem_valid,
    output logic                              mem_ready,
    input  core_pkg::mem_word_u               mem_data,
    output logic                              wb_valid,
    input  logic                              wb_ready,
    output core_pkg::core_result_t            wb_result,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_isa_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv_isa_pkg::xlen-1:0]       rs2_data
);

    import core_pkg::*;

    logic         head_valid;
    load_cmd_t    head;
    core_result_t load_result;
    logic         load_valid;  // Command and data both present
    logic         wb_fire;

    assign load_valid = head_valid && mem_valid;
    assign wb_fire    = wb_valid && wb_ready;

    load_cmd_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .push_valid (load_cmd_valid),
        .push_ready (load_cmd_ready),
        .push_cmd   (load_cmd),
        .head_valid (head_valid),
        .head       (head),
        .pop        (mem_ready)  // Same pulse as load_take
    );

    load_align u_align (
        .cmd    (head),
        .data   (mem_data),
        .result (load_result)
    );

    writeback_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .exec_result (exec_result),
        .sys_valid   (sys_valid),
        .sys_ready   (sys_ready),
        .sys_result  (sys_result),
        .load_valid  (load_valid),
        .load_result (load_result),
        .load_take   (mem_ready),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_result   (wb_result)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wb_fire),
        .wr       (wb_result),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

/* tb/writeback_tb.sv */
module writeback_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int src_exec = 0;  // Same cyclic order as the arbiter rotation
    localparam int src_load = 1;
    localparam int src_sys  = 2;
    localparam int group_timeout = 300;

    // One table row with the expected result of its own step
    typedef struct packed {
        logic         exec_v;
        logic         sys_v;
        logic         cmd_v;
        logic         mem_v;
        core_result_t res;      // Exec or sys payload
        load_cmd_t    cmd;
        mem_word_u    mem;
        logic         stall;    // Random wb_ready while this step is at the output
        logic [1:0]   exp_src;
        core_result_t exp;
    } step_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  exec_valid;
    logic                  exec_ready;
    core_result_t          exec_result;
    logic                  sys_valid;
    logic                  sys_ready;
    core_result_t          sys_result;
    logic                  load_cmd_valid;
    logic                  load_cmd_ready;
    load_cmd_t             load_cmd;
    logic                  mem_valid;
    logic                  mem_ready;
    mem_word_u             mem_data;
    logic                  wb_valid;
    logic                  wb_ready;
    core_result_t          wb_result;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [xlen-1:0]       rs1_data;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs2_data;

    step_t                 rows[$];
    logic [xlen-1:0]       m_regs [32];  // Reference register file
    int                    m_prio;       // Reference priority holder
    logic                  m_out_v;      // Reference output register
    int                    m_out_row;
    logic [reg_addr_w-1:0] last_wr;
    int                    tick;
    int                    checks;
    int                    errors;
    logic                  timed_out;

    writeback_top dut_i (.*);

    always #4 clk = ~clk;

    task automatic compare_value(input string name, input logic [39:0] got,
                                 input logic [39:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Load extraction straight from the alignment rules
    function automatic logic [31:0] align_ref(input load_op_t op, input logic [1:0] off,
                                              input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            lb:      return {{24{b[7]}}, b};
            lbu:     return {24'h0, b};
            lh:      return {{16{h[15]}}, h};
            lhu:     return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // First valid source in cyclic order from the holder
    function automatic int pick_src(input int prio, input logic [2:0] req);
        int idx;
        for (int i = 0; i < 3; i++) begin
            idx = (prio + i) % 3;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic core_result_t make_res(input int addr, input logic [31:0] value,
                                              input logic spec);
        core_result_t r;
        r.addr        = reg_addr_w'(addr);
        r.value       = value;
        r.speculative = spec;
        return r;
    endfunction

    function automatic load_cmd_t make_cmd(input int addr, input int off, input load_op_t op);
        load_cmd_t c;
        c.addr   = reg_addr_w'(addr);
        c.offset = 2'(off);
        c.op     = op;
        return c;
    endfunction

    task automatic add_step(input int src, input core_result_t res, input load_cmd_t cmd,
                            input logic [31:0] word, input logic stall);
        step_t s;
        s         = '0;
        s.exec_v  = (src == src_exec);
        s.sys_v   = (src == src_sys);
        s.cmd_v   = (src == src_load);
        s.mem_v   = (src == src_load);
        s.res     = res;
        s.cmd     = cmd;
        s.mem     = word;
        s.stall   = stall;
        s.exp_src = 2'(src);
        if (src == src_load) begin
            s.exp = make_res(cmd.addr, align_ref(cmd.op, cmd.offset, word), 1'b0);
        end else begin
            s.exp = res;
        end
        rows.push_back(s);
    endtask

    task automatic build_table();
        load_op_t   ops [5] = '{lb, lh, lw, lbu, lhu};
        load_cmd_t  no_cmd;
        logic [4:0] k;
        no_cmd = make_cmd(0, 0, lw);
        // Rows 0 to 11 with every source busy and the first write to x0
        for (int r = 0; r < 4; r++) begin
            k = 5'(r);
            add_step(src_exec, make_res(r, 32'h1111_0000 + r, k[0]), no_cmd, '0, 1'b0);
            add_step(src_load, '0, make_cmd(8 + r, r, lw), 32'hCAFE_0000 + r, 1'b0);
            add_step(src_sys, make_res(16 + r, 32'h5555_0000 + r, !k[0]), no_cmd, '0, 1'b0);
        end
        // Rows 12 to 31 cover every op at every offset with byte top bits set
        for (int i = 0; i < 20; i++) begin
            add_step(src_load, '0, make_cmd(1 + i, i % 4, ops[i / 4]),
                     32'h8F9E_ADBC + i * 32'h0101_0101, 1'b0);
        end
        // Rows 32 to 38 pile up commands before any data
        for (int i = 0; i < 7; i++) begin
            add_step(src_load, '0, make_cmd(21 + i, i % 4, ops[i % 5]),
                     32'hF0E1_D2C3 - i * 32'h1111_1111, 1'b0);
        end
        // Rows 39 to 50 use exec and sys only under random stalls
        for (int i = 0; i < 12; i++) begin
            k = 5'(i);
            add_step((i % 3 == 0) ? src_exec : src_sys,
                     make_res(28 + i % 4, 32'hB000_0000 + i * 32'h0101_0101, k[0]),
                     no_cmd, '0, 1'b1);
        end
    endtask

    // Runs table rows first to last between two falling edges
    task automatic run_group(input int first, input int last, input logic hold_mem);
        int           exec_q[$];
        int           sys_q[$];
        int           cmd_q[$];
        int           mem_q[$];
        int           pend_cmd[$];  // Commands the queue holds
        int           next_exp;
        int           cycles;
        int           full_cycles;
        int           win;
        int           win_row;
        int           cur;
        logic         mem_hold;
        logic [2:0]   req;
        logic         cmd_rdy;
        logic         took_exec;
        logic         took_load;
        logic         took_sys;
        logic         cmd_push;
        logic         wb_fire;
        for (int i = first; i <= last; i++) begin
            if (rows[i].exec_v) exec_q.push_back(i);
            if (rows[i].sys_v) sys_q.push_back(i);
            if (rows[i].cmd_v) cmd_q.push_back(i);
            if (rows[i].mem_v) mem_q.push_back(i);
        end
        next_exp    = first;
        cycles      = 0;
        full_cycles = 0;
        mem_hold    = hold_mem;
        while (next_exp <= last || m_out_v) begin
            if (cycles >= group_timeout) begin
                $display("Timeout: steps %0d to %0d did not drain within %0d cycles",
                         first, last, cycles);
                errors++;
                timed_out = 1'b1;
                return;
            end
            cur            = m_out_v ? m_out_row : next_exp;
            exec_valid     = (exec_q.size() > 0);
            exec_result    = exec_valid ? rows[exec_q[0]].res : '0;
            sys_valid      = (sys_q.size() > 0);
            sys_result     = sys_valid ? rows[sys_q[0]].res : '0;
            load_cmd_valid = (cmd_q.size() > 0);
            load_cmd       = load_cmd_valid ? rows[cmd_q[0]].cmd : '0;
            mem_valid      = (mem_q.size() > 0) && !mem_hold;
            mem_data       = (mem_q.size() > 0) ? rows[mem_q[0]].mem : '0;
            wb_ready       = rows[cur].stall ? (($urandom % 2) == 1) : 1'b1;
            rs1_addr       = last_wr;
            rs2_addr       = reg_addr_w'(tick);
            #1;
            req[src_exec] = exec_valid;
            req[src_load] = (pend_cmd.size() > 0) && mem_valid;
            req[src_sys]  = sys_valid;
            win     = (!m_out_v || wb_ready) ? pick_src(m_prio, req) : -1;
            cmd_rdy = (pend_cmd.size() < load_queue_depth) || (win == src_load);
            compare_value("wb_valid", wb_valid, m_out_v);
            if (m_out_v) compare_value("wb_result", wb_result, rows[m_out_row].exp);
            compare_value("exec_ready", exec_ready, win == src_exec);
            compare_value("mem_ready", mem_ready, win == src_load);
            compare_value("sys_ready", sys_ready, win == src_sys);
            compare_value("load_cmd_ready", load_cmd_ready, cmd_rdy);
            compare_value("rs1_data", rs1_data, m_regs[rs1_addr]);
            compare_value("rs2_data", rs2_data, m_regs[rs2_addr]);
            if (win >= 0) begin
                case (win)
                    src_exec: win_row = exec_q[0];
                    src_load: win_row = pend_cmd[0];
                    default:  win_row = sys_q[0];
                endcase
                checks++;
                if (win_row != next_exp || int'(rows[next_exp].exp_src) != win) begin
                    errors++;
                    $display("Arbitration order wrong: model grants step %0d from source %0d,",
                             win_row, win);
                    $display("  but the table expects step %0d from source %0d",
                             next_exp, rows[next_exp].exp_src);
                end
            end
            if (mem_hold && !cmd_rdy) full_cycles++;
            if (full_cycles >= 3) mem_hold = 1'b0;  // Queue held full long enough
            took_exec = (win == src_exec);
            took_load = (win == src_load);
            took_sys  = (win == src_sys);
            cmd_push  = load_cmd_valid && cmd_rdy;
            wb_fire   = m_out_v && wb_ready;
            @(posedge clk);
            if (wb_fire) begin
                if (rows[m_out_row].exp.addr != '0) begin
                    m_regs[rows[m_out_row].exp.addr] = rows[m_out_row].exp.value;
                end
                last_wr = rows[m_out_row].exp.addr;
                m_out_v = 1'b0;
            end
            if (took_exec || took_load || took_sys) begin
                if (took_exec) begin
                    m_out_row = exec_q.pop_front();
                end else if (took_load) begin
                    m_out_row = pend_cmd.pop_front();
                    void'(mem_q.pop_front());
                end else begin
                    m_out_row = sys_q.pop_front();
                end
                m_out_v = 1'b1;
                m_prio  = (m_prio + 1) % 3;
                next_exp++;
            end
            if (cmd_push) pend_cmd.push_back(cmd_q.pop_front());
            @(negedge clk);
            tick++;
            cycles++;
        end
    endtask

    initial begin
        void'($urandom(33229));
        rst            = 1'b1;
        exec_valid     = 1'b0;
        exec_result    = '0;
        sys_valid      = 1'b0;
        sys_result     = '0;
        load_cmd_valid = 1'b0;
        load_cmd       = '0;
        mem_valid      = 1'b0;
        mem_data       = '0;
        wb_ready       = 1'b0;
        rs1_addr       = 5'd1;
        rs2_addr       = 5'd31;
        m_prio         = src_exec;
        m_out_v        = 1'b0;
        m_out_row      = 0;
        last_wr        = '0;
        tick           = 0;
        checks         = 0;
        errors         = 0;
        timed_out      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        compare_value("wb_valid", wb_valid, 1'b0);
        compare_value("exec_ready", exec_ready, 1'b0);
        compare_value("sys_ready", sys_ready, 1'b0);
        compare_value("mem_ready", mem_ready, 1'b0);
        compare_value("load_cmd_ready", load_cmd_ready, 1'b1);
        compare_value("rs1_data", rs1_data, '0);
        compare_value("rs2_data", rs2_data, '0);
        @(negedge clk);
        run_group(0, 11, 1'b0);
        if (!timed_out) begin
            run_group(12, 31, 1'b0);
        end
        if (!timed_out) begin
            run_group(32, 38, 1'b1);
        end
        if (!timed_out) begin
            run_group(39, 50, 1'b0);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/rv_isa_pkg.sv
design/core_pkg.sv
design/load_align.sv
design/load_cmd_queue.sv
design/writeback_arbiter.sv
design/reg_file.sv
design/writeback_top.sv
tb/writeback_tb.sv
